// File: logic/shared_tlb_params.svh
`ifndef SHARED_TLB_PARAMS_SVH
`define SHARED_TLB_PARAMS_SVH

// Number of sets, indexed by the low bits of vpn1.
`define SHARED_TLB_SETS 16

// Ways per set.
`define SHARED_TLB_WAYS 4

// Address space identifier width for Sv32.
`define SHARED_TLB_ASID_W 9

// Reset value of the 8-bit replacement LFSR. It must be nonzero.
`define SHARED_TLB_LFSR_SEED 8'hb4

`endif

// File: logic/shared_tlb_pkg.sv
`include "shared_tlb_params.svh"

package shared_tlb_pkg;

  // 4 KiB page view of a virtual address.
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [9:0]  vpn0;
    logic [11:0] offset;
  } sv32_page_va_t;

  // 4 MiB superpage view of a virtual address.
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [21:0] offset;
  } sv32_mega_va_t;

  typedef union packed {
    sv32_page_va_t page;
    sv32_mega_va_t mega;
  } sv32_vaddr_t;

  // Leaf page table entry.
  typedef struct packed {
    logic [21:0] ppn;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } sv32_pte_t;

  // Translation exchanged with the L1 TLBs and the walker.
  typedef struct packed {
    logic                          valid;
    logic                          is_4m;
    logic [19:0]                   vpn;
    logic [`SHARED_TLB_ASID_W-1:0] asid;
    sv32_pte_t                     content;
  } tlb_update_t;

  typedef struct packed {
    logic                          valid;
    logic                          is_4m;
    logic [9:0]                    vpn1;
    logic [9:0]                    vpn0;
    logic [`SHARED_TLB_ASID_W-1:0] asid;
    sv32_pte_t                     pte;
  } tlb_entry_t;

endpackage

// File: logic/tlb_lookup_if.sv
`timescale 1ns/1ns
`include "shared_tlb_params.svh"

interface tlb_lookup_if;

  logic                          valid;
  logic                          is_itlb;
  shared_tlb_pkg::sv32_vaddr_t   vaddr;
  logic [`SHARED_TLB_ASID_W-1:0] asid;

  // Arbiter side.
  modport req (
    output valid, is_itlb, vaddr, asid
  );

  // Store side.
  modport rsp (
    input valid, is_itlb, vaddr, asid
  );

endinterface

// File: logic/shared_tlb_arbiter.sv
`timescale 1ns/1ns
`include "shared_tlb_params.svh"

module shared_tlb_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  logic                          enable_translation_i,
  input  logic                          en_ld_st_translation_i,
  input  logic [`SHARED_TLB_ASID_W-1:0] asid_i,
  input  logic                          itlb_access_i,
  input  logic                          itlb_hit_i,
  input  shared_tlb_pkg::sv32_vaddr_t   itlb_vaddr_i,
  input  logic                          dtlb_access_i,
  input  logic                          dtlb_hit_i,
  input  shared_tlb_pkg::sv32_vaddr_t   dtlb_vaddr_i,
  tlb_lookup_if.req                     lookup,
  output logic                          shared_tlb_access_o,
  output logic                          itlb_req_o,
  output shared_tlb_pkg::sv32_vaddr_t   shared_tlb_vaddr_o
);

  logic                          itlb_miss;
  logic                          dtlb_miss;
  logic                          any_miss;

  logic                          valid_q;
  logic                          is_itlb_q;
  shared_tlb_pkg::sv32_vaddr_t   vaddr_q;
  logic [`SHARED_TLB_ASID_W-1:0] asid_q;

  // A miss only counts while translation is on for that side.
  assign itlb_miss = itlb_access_i & ~itlb_hit_i & enable_translation_i;
  assign dtlb_miss = dtlb_access_i & ~dtlb_hit_i & en_ld_st_translation_i;
  assign any_miss  = itlb_miss | dtlb_miss;

  // Instruction side wins a tie; a dropped data miss is retried by the L1.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      is_itlb_q <= 1'b0;
    end else if (flush_i) begin
      valid_q   <= 1'b0;
      is_itlb_q <= 1'b0;
    end else begin
      valid_q   <= any_miss;
      is_itlb_q <= itlb_miss;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_miss) begin
      vaddr_q <= itlb_miss ? itlb_vaddr_i : dtlb_vaddr_i;
      asid_q  <= asid_i;
    end
  end

  assign lookup.valid   = valid_q;
  assign lookup.is_itlb = is_itlb_q;
  assign lookup.vaddr   = vaddr_q;
  assign lookup.asid    = asid_q;

  // Observation outputs follow the registered request.
  assign shared_tlb_access_o = valid_q;
  assign itlb_req_o          = is_itlb_q;
  assign shared_tlb_vaddr_o  = vaddr_q;

endmodule

// File: logic/shared_tlb_store.sv
`timescale 1ns/1ns
`include "shared_tlb_params.svh"

module shared_tlb_store (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        flush_i,
  tlb_lookup_if.rsp                   lookup,
  input  shared_tlb_pkg::tlb_update_t shared_tlb_update_i,
  output shared_tlb_pkg::tlb_update_t itlb_update_o,
  output shared_tlb_pkg::tlb_update_t dtlb_update_o,
  output logic                        itlb_miss_o,
  output logic                        dtlb_miss_o,
  output logic                        shared_tlb_hit_o
);

  localparam int SETS   = `SHARED_TLB_SETS;
  localparam int WAYS   = `SHARED_TLB_WAYS;
  localparam int IDX_W  = $clog2(SETS);
  localparam int WAY_W  = $clog2(WAYS);
  localparam int LFSR_W = 8;

  // Valid bits are kept apart from the payload so flush is a single clear.
  logic [WAYS-1:0]             valid_q [SETS];
  shared_tlb_pkg::tlb_entry_t  entry_q [SETS][WAYS];

  logic [IDX_W-1:0]            rd_idx;
  shared_tlb_pkg::tlb_entry_t  rd_entry [WAYS];
  logic [WAYS-1:0]             hit_way;
  shared_tlb_pkg::tlb_entry_t  hit_entry;
  shared_tlb_pkg::tlb_update_t hit_update;

  logic                        res_valid_q;
  logic                        res_itlb_q;
  shared_tlb_pkg::tlb_update_t res_update_q;

  logic                        wr_en;
  logic [IDX_W-1:0]            wr_idx;
  logic [WAYS-1:0]             wr_set_valid;
  logic [WAY_W-1:0]            wr_way;
  shared_tlb_pkg::tlb_entry_t  wr_entry;
  logic [LFSR_W-1:0]           lfsr_q;

  // Regular pages and superpages both index by vpn1.
  assign rd_idx = lookup.vaddr.mega.vpn1[IDX_W-1:0];

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      rd_entry[w]       = entry_q[rd_idx][w];
      rd_entry[w].valid = valid_q[rd_idx][w];
    end
  end

  // Compare all ways; the lowest hitting way is taken.
  always_comb begin
    hit_way   = '0;
    hit_entry = rd_entry[0];
    for (int w = WAYS - 1; w >= 0; w--) begin
      hit_way[w] = rd_entry[w].valid &&
                   (rd_entry[w].vpn1 == lookup.vaddr.mega.vpn1) &&
                   (rd_entry[w].is_4m || (rd_entry[w].vpn0 == lookup.vaddr.page.vpn0)) &&
                   (rd_entry[w].pte.g || (rd_entry[w].asid == lookup.asid));
      if (hit_way[w]) begin
        hit_entry = rd_entry[w];
      end
    end
  end

  // A superpage hit returns the request's vpn0.
  always_comb begin
    hit_update.valid   = |hit_way;
    hit_update.is_4m   = hit_entry.is_4m;
    hit_update.vpn     = {hit_entry.vpn1, lookup.vaddr.page.vpn0};
    hit_update.asid    = hit_entry.asid;
    hit_update.content = hit_entry.pte;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
      res_itlb_q  <= 1'b0;
    end else begin
      res_valid_q <= lookup.valid & ~flush_i;
      res_itlb_q  <= lookup.is_itlb;
    end
  end

  // Result payload; its valid field holds the hit flag.
  always_ff @(posedge clk_i) begin
    res_update_q <= hit_update;
  end

  assign shared_tlb_hit_o = res_valid_q & res_update_q.valid;
  assign itlb_miss_o      = res_valid_q & ~res_update_q.valid & res_itlb_q;
  assign dtlb_miss_o      = res_valid_q & ~res_update_q.valid & ~res_itlb_q;

  always_comb begin
    itlb_update_o       = res_update_q;
    itlb_update_o.valid = res_valid_q & res_update_q.valid & res_itlb_q;
    dtlb_update_o       = res_update_q;
    dtlb_update_o.valid = res_valid_q & res_update_q.valid & ~res_itlb_q;
  end

  // Refill path. Flush wins over a refill in the same cycle.
  assign wr_en        = shared_tlb_update_i.valid & ~flush_i;
  assign wr_idx       = shared_tlb_update_i.vpn[10 +: IDX_W];
  assign wr_set_valid = valid_q[wr_idx];

  // The first invalid way is taken and otherwise the LFSR picks the victim.
  always_comb begin
    wr_way = lfsr_q[WAY_W-1:0];
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!wr_set_valid[w]) begin
        wr_way = WAY_W'(w);
      end
    end
  end

  always_comb begin
    wr_entry.valid = 1'b1;
    wr_entry.is_4m = shared_tlb_update_i.is_4m;
    wr_entry.vpn1  = shared_tlb_update_i.vpn[19:10];
    wr_entry.vpn0  = shared_tlb_update_i.vpn[9:0];
    wr_entry.asid  = shared_tlb_update_i.asid;
    wr_entry.pte   = shared_tlb_update_i.content;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '{default: '0};
    end else if (flush_i) begin
      valid_q <= '{default: '0};
    end else if (wr_en) begin
      valid_q[wr_idx][wr_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      entry_q[wr_idx][wr_way] <= wr_entry;
    end
  end

  // Fibonacci LFSR with polynomial x^8 + x^6 + x^5 + x^4 + 1 that steps on each refill.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= `SHARED_TLB_LFSR_SEED;
    end else if (wr_en) begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

endmodule

// File: logic/shared_tlb_top.sv
`timescale 1ns/1ns
`include "shared_tlb_params.svh"

module shared_tlb_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  logic                          enable_translation_i,
  input  logic                          en_ld_st_translation_i,
  input  logic [`SHARED_TLB_ASID_W-1:0] asid_i,
  input  logic                          itlb_access_i,
  input  logic                          itlb_hit_i,
  input  shared_tlb_pkg::sv32_vaddr_t   itlb_vaddr_i,
  input  logic                          dtlb_access_i,
  input  logic                          dtlb_hit_i,
  input  shared_tlb_pkg::sv32_vaddr_t   dtlb_vaddr_i,
  input  shared_tlb_pkg::tlb_update_t   shared_tlb_update_i,
  output shared_tlb_pkg::tlb_update_t   itlb_update_o,
  output shared_tlb_pkg::tlb_update_t   dtlb_update_o,
  output logic                          itlb_miss_o,
  output logic                          dtlb_miss_o,
  output logic                          shared_tlb_access_o,
  output logic                          shared_tlb_hit_o,
  output shared_tlb_pkg::sv32_vaddr_t   shared_tlb_vaddr_o,
  output logic                          itlb_req_o
);

  tlb_lookup_if lookup ();

  shared_tlb_arbiter i_arbiter (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .flush_i                (flush_i),
    .enable_translation_i   (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .asid_i                 (asid_i),
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .lookup                 (lookup.req),
    .shared_tlb_access_o    (shared_tlb_access_o),
    .itlb_req_o             (itlb_req_o),
    .shared_tlb_vaddr_o     (shared_tlb_vaddr_o)
  );

  shared_tlb_store i_store (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .flush_i             (flush_i),
    .lookup              (lookup.rsp),
    .shared_tlb_update_i (shared_tlb_update_i),
    .itlb_update_o       (itlb_update_o),
    .dtlb_update_o       (dtlb_update_o),
    .itlb_miss_o         (itlb_miss_o),
    .dtlb_miss_o         (dtlb_miss_o),
    .shared_tlb_hit_o    (shared_tlb_hit_o)
  );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset is held low for four rising edges.
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: test/shared_tlb_tb.sv
`timescale 1ns/1ns
`include "shared_tlb_params.svh"

module shared_tlb_tb;

  localparam int ASID_W       = `SHARED_TLB_ASID_W;
  localparam int RAND_ENTRIES = 40;
  localparam int RAND_LOOKUPS = 60;
  // Directed tests take about 40 cycles and each random lookup takes two.
  localparam int TEST_CYCLES  = 40 + RAND_ENTRIES + 2 * RAND_LOOKUPS;

  logic clk_i, rst_n_i, flush_i, enable_translation_i, en_ld_st_translation_i;
  logic itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i;
  logic [ASID_W-1:0] asid_i;
  shared_tlb_pkg::sv32_vaddr_t itlb_vaddr_i, dtlb_vaddr_i, shared_tlb_vaddr_o;
  shared_tlb_pkg::tlb_update_t shared_tlb_update_i, itlb_update_o, dtlb_update_o;
  logic itlb_miss_o, dtlb_miss_o, shared_tlb_access_o, shared_tlb_hit_o, itlb_req_o;

  // Reference copy of every translation written since the last flush.
  shared_tlb_pkg::tlb_update_t model_q [$];
  int err_update = 0;
  int err_bit    = 0;
  int err_vaddr  = 0;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  shared_tlb_top i_dut (.*);

  task automatic compare_update(input string name, input shared_tlb_pkg::tlb_update_t act,
                                input shared_tlb_pkg::tlb_update_t exp);
    if (act !== exp) begin
      err_update++;
      $display("error %s: got %h, expected %h", name, act, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      err_bit++;
      $display("error %s: got %h, expected %h", name, act, exp);
    end
  endtask

  task automatic compare_vaddr(input string name, input shared_tlb_pkg::sv32_vaddr_t act,
                               input shared_tlb_pkg::sv32_vaddr_t exp);
    if (act !== exp) begin
      err_vaddr++;
      $display("error %s: got %h, expected %h", name, act, exp);
    end
  endtask

  function automatic shared_tlb_pkg::tlb_update_t make_entry(input logic [19:0] vpn,
      input logic is_4m, input logic [ASID_W-1:0] asid, input logic g, input logic [21:0] ppn);
    shared_tlb_pkg::tlb_update_t u;
    u             = '0;
    u.valid       = 1'b1;
    u.is_4m       = is_4m;
    u.vpn         = vpn;
    u.asid        = asid;
    u.content.ppn = ppn;
    u.content.g   = g;
    u.content.r   = 1'b1;
    u.content.v   = 1'b1;
    return u;
  endfunction

  // A translation matches on vpn1, on vpn0 unless a superpage, and on ASID unless global.
  function automatic logic predict(input shared_tlb_pkg::sv32_vaddr_t va,
      input logic [ASID_W-1:0] asid, output shared_tlb_pkg::tlb_update_t want);
    shared_tlb_pkg::tlb_update_t e;
    want = '0;
    foreach (model_q[i]) begin
      e = model_q[i];
      if ((e.vpn[19:10] == va.page.vpn1) && (e.is_4m || (e.vpn[9:0] == va.page.vpn0)) &&
          (e.content.g || (e.asid == asid))) begin
        want         = e;
        want.vpn[9:0] = va.page.vpn0;
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic refill(input shared_tlb_pkg::tlb_update_t e);
    shared_tlb_update_i = e;
    @(posedge clk_i);
    #1;
    shared_tlb_update_i = '0;
    model_q.push_back(e);
  endtask

  task automatic flush_tlb();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    model_q.delete();
  endtask

  task automatic check_result(input logic is_itlb, input logic exp_hit,
                              input shared_tlb_pkg::tlb_update_t exp_upd);
    compare_bit("shared_tlb_hit_o", shared_tlb_hit_o, exp_hit);
    compare_bit("itlb_miss_o", itlb_miss_o, is_itlb & ~exp_hit);
    compare_bit("dtlb_miss_o", dtlb_miss_o, ~is_itlb & ~exp_hit);
    compare_bit("itlb_update_o.valid", itlb_update_o.valid, is_itlb & exp_hit);
    compare_bit("dtlb_update_o.valid", dtlb_update_o.valid, ~is_itlb & exp_hit);
    if (exp_hit && is_itlb) begin
      compare_update("itlb_update_o", itlb_update_o, exp_upd);
    end else if (exp_hit) begin
      compare_update("dtlb_update_o", dtlb_update_o, exp_upd);
    end
  endtask

  // No hit, no miss and no valid update in this cycle.
  task automatic check_no_result();
    compare_bit("shared_tlb_hit_o", shared_tlb_hit_o, 1'b0);
    compare_bit("itlb_miss_o", itlb_miss_o, 1'b0);
    compare_bit("dtlb_miss_o", dtlb_miss_o, 1'b0);
    compare_bit("itlb_update_o.valid", itlb_update_o.valid, 1'b0);
    compare_bit("dtlb_update_o.valid", dtlb_update_o.valid, 1'b0);
  endtask

  // Presents one L1 miss and checks the request cycle and the result two cycles later.
  task automatic do_lookup(input logic is_itlb, input shared_tlb_pkg::sv32_vaddr_t va,
      input logic [ASID_W-1:0] asid, input logic exp_hit,
      input shared_tlb_pkg::tlb_update_t exp_upd);
    asid_i        = asid;
    itlb_access_i = is_itlb;
    dtlb_access_i = ~is_itlb;
    itlb_vaddr_i  = va;
    dtlb_vaddr_i  = va;
    @(posedge clk_i);
    #1;
    itlb_access_i = 1'b0;
    dtlb_access_i = 1'b0;
    compare_bit("shared_tlb_access_o", shared_tlb_access_o, 1'b1);
    compare_bit("itlb_req_o", itlb_req_o, is_itlb);
    compare_vaddr("shared_tlb_vaddr_o", shared_tlb_vaddr_o, va);
    @(posedge clk_i);
    #1;
    check_result(is_itlb, exp_hit, exp_upd);
  endtask

  task automatic test_reset();
    compare_bit("shared_tlb_access_o", shared_tlb_access_o, 1'b0);
    compare_bit("itlb_req_o", itlb_req_o, 1'b0);
    check_no_result();
    // Misses with translation off must be ignored.
    itlb_access_i = 1'b1;
    dtlb_access_i = 1'b1;
    @(posedge clk_i);
    #1;
    itlb_access_i = 1'b0;
    dtlb_access_i = 1'b0;
    compare_bit("shared_tlb_access_o", shared_tlb_access_o, 1'b0);
    @(posedge clk_i);
    #1;
    check_no_result();
    enable_translation_i   = 1'b1;
    en_ld_st_translation_i = 1'b1;
  endtask

  task automatic test_itlb_refill();
    shared_tlb_pkg::sv32_vaddr_t va;
    shared_tlb_pkg::tlb_update_t e;
    va = 32'h0040_3abc;
    e  = make_entry({va.page.vpn1, va.page.vpn0}, 1'b0, 9'd5, 1'b0, 22'h12345);
    do_lookup(1'b1, va, 9'd5, 1'b0, '0);
    refill(e);
    do_lookup(1'b1, va, 9'd5, 1'b1, e);
  endtask

  task automatic test_arbitration();
    shared_tlb_pkg::sv32_vaddr_t ia, da;
    shared_tlb_pkg::tlb_update_t ie, de;
    ia = 32'h0080_5000;
    da = 32'h00c0_6000;
    ie = make_entry({ia.page.vpn1, ia.page.vpn0}, 1'b0, 9'd5, 1'b0, 22'h0aaaa);
    de = make_entry({da.page.vpn1, da.page.vpn0}, 1'b0, 9'd5, 1'b0, 22'h0bbbb);
    refill(ie);
    refill(de);
    asid_i        = 9'd5;
    itlb_access_i = 1'b1;
    dtlb_access_i = 1'b1;
    itlb_vaddr_i  = ia;
    dtlb_vaddr_i  = da;
    @(posedge clk_i);
    #1;
    // The data side still misses and presents its request again.
    itlb_access_i = 1'b0;
    compare_bit("shared_tlb_access_o", shared_tlb_access_o, 1'b1);
    compare_bit("itlb_req_o", itlb_req_o, 1'b1);
    compare_vaddr("shared_tlb_vaddr_o", shared_tlb_vaddr_o, ia);
    @(posedge clk_i);
    #1;
    dtlb_access_i = 1'b0;
    check_result(1'b1, 1'b1, ie);
    compare_bit("shared_tlb_access_o", shared_tlb_access_o, 1'b1);
    compare_bit("itlb_req_o", itlb_req_o, 1'b0);
    compare_vaddr("shared_tlb_vaddr_o", shared_tlb_vaddr_o, da);
    @(posedge clk_i);
    #1;
    check_result(1'b0, 1'b1, de);
  endtask

  task automatic test_superpage_asid();
    shared_tlb_pkg::sv32_vaddr_t va;
    shared_tlb_pkg::tlb_update_t sp, ge, want;
    sp = make_entry({10'h2c1, 10'h000}, 1'b1, 9'd7, 1'b0, 22'h3f000);
    ge = make_entry({10'h31f, 10'h02a}, 1'b0, 9'd3, 1'b1, 22'h01234);
    refill(sp);
    refill(ge);
    va   = {10'h2c1, 10'h155, 12'h3c0};
    want = sp;
    want.vpn[9:0] = 10'h155;
    do_lookup(1'b0, va, 9'd7, 1'b1, want);
    va   = {10'h2c1, 10'h2e9, 12'h004};
    want.vpn[9:0] = 10'h2e9;
    do_lookup(1'b1, va, 9'd7, 1'b1, want);
    do_lookup(1'b1, va, 9'd8, 1'b0, '0);
    va = {10'h31f, 10'h02a, 12'h800};
    do_lookup(1'b0, va, 9'd100, 1'b1, ge);
  endtask

  task automatic test_flush();
    shared_tlb_pkg::sv32_vaddr_t va;
    shared_tlb_pkg::tlb_update_t e;
    va = 32'h1234_5678;
    e  = make_entry({va.page.vpn1, va.page.vpn0}, 1'b0, 9'd1, 1'b0, 22'h2beef);
    refill(e);
    do_lookup(1'b0, va, 9'd1, 1'b1, e);
    flush_tlb();
    do_lookup(1'b0, va, 9'd1, 1'b0, '0);
    refill(e);
    dtlb_access_i = 1'b1;
    dtlb_vaddr_i  = va;
    @(posedge clk_i);
    #1;
    dtlb_access_i = 1'b0;
    flush_i       = 1'b1;
    compare_bit("shared_tlb_access_o", shared_tlb_access_o, 1'b1);
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    model_q.delete();
    check_no_result();
  endtask

  task automatic test_random();
    int set_cnt [16];
    logic [31:0] r;
    logic [9:0] vpn1;
    logic exp_hit;
    int idx;
    shared_tlb_pkg::sv32_vaddr_t va;
    shared_tlb_pkg::tlb_update_t want;
    flush_tlb();
    foreach (set_cnt[i]) set_cnt[i] = 0;
    // Upper vpn1 bits follow the loop count, so no two entries overlap.
    for (int n = 0; n < RAND_ENTRIES; n++) begin
      r    = $urandom();
      vpn1 = {n[5:0], r[3:0]};
      if (set_cnt[r[3:0]] < 4) begin
        set_cnt[r[3:0]]++;
        refill(make_entry({vpn1, r[13:4]}, r[14] & r[15], ASID_W'(r[17:16]), r[18] & r[19],
                          r[31:10]));
      end
    end
    for (int n = 0; n < RAND_LOOKUPS; n++) begin
      r  = $urandom();
      va = $urandom();
      if (r[0] && (model_q.size() > 0)) begin
        idx = $urandom_range(model_q.size() - 1, 0);
        va.page.vpn1 = model_q[idx].vpn[19:10];
        if (!model_q[idx].is_4m) va.page.vpn0 = model_q[idx].vpn[9:0];
      end
      exp_hit = predict(va, ASID_W'(r[2:1]), want);
      do_lookup(r[3], va, ASID_W'(r[2:1]), exp_hit, want);
    end
  endtask

  initial begin
    #(TEST_CYCLES * 20 + 1000);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hd752_847d));
    flush_i                = 1'b0;
    enable_translation_i   = 1'b0;
    en_ld_st_translation_i = 1'b0;
    asid_i                 = '0;
    itlb_access_i          = 1'b0;
    itlb_hit_i             = 1'b0;
    itlb_vaddr_i           = '0;
    dtlb_access_i          = 1'b0;
    dtlb_hit_i             = 1'b0;
    dtlb_vaddr_i           = '0;
    shared_tlb_update_i    = '0;
    wait (rst_n_i === 1'b1);
    @(posedge clk_i);
    #1;
    test_reset();
    test_itlb_refill();
    test_arbitration();
    test_superpage_asid();
    test_flush();
    test_random();
    $display("Errors: update=%0d flag=%0d vaddr=%0d", err_update, err_bit, err_vaddr);
    if (err_update + err_bit + err_vaddr == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: shared_tlb_top.f
+incdir+logic
logic/shared_tlb_pkg.sv
logic/tlb_lookup_if.sv
logic/shared_tlb_arbiter.sv
logic/shared_tlb_store.sv
logic/shared_tlb_top.sv
test/tb_clock_gen.sv
test/shared_tlb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module shared_tlb_tb -Mdir build -o sim_shared_tlb \
  -f shared_tlb_top.f \
  && ./build/sim_shared_tlb | tee sim.log \
  || { echo "Simulation did not build or run"; exit 1; }

grep -q "Test failed" sim.log && exit 1 || exit 0
